// ==== hdl/video_pkg.sv ====
/*
 * Video path package
 * Timing constants for 640x480 at 60 Hz, pixel types and the packed
 * structs shared by the capture, FIFO and scan-out blocks
 */

package video_pkg;

	//============================================================
	// Timing, 640x480 at 60 Hz on a 25.2 MHz pixel clock
	//============================================================
	localparam int H_ACTIVE = 640;
	localparam int H_FP     = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BP     = 48;
	localparam int H_TOTAL  = 800;   // Sum of the four regions

	localparam int V_ACTIVE = 480;
	localparam int V_FP     = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BP     = 33;
	localparam int V_TOTAL  = 525;

	localparam int FRAME_PIXELS = 307200;   // H_ACTIVE * V_ACTIVE

	// Pixel FIFO geometry
	localparam int FIFO_DEPTH = 1024;
	localparam int FIFO_AW    = 10;

	//============================================================
	// Types
	//============================================================
	typedef logic [9:0]         hcount_t;      // Horizontal position
	typedef logic [9:0]         vcount_t;      // Vertical position
	typedef logic [18:0]        pix_count_t;   // Pixels within a frame
	typedef logic [7:0]         cam_byte_t;    // One camera bus byte
	typedef logic [15:0]        rgb565_t;      // R5 G6 B5
	typedef logic [23:0]        rgb_t;         // R8 G8 B8, red on top
	typedef logic [FIFO_AW:0]   fifo_ptr_t;    // Address plus wrap bit

	localparam rgb_t PATTERN_RED  = 24'hFF0000;
	localparam rgb_t PATTERN_BLUE = 24'h0000FF;
	localparam rgb_t BLACK        = 24'h000000;

	typedef struct packed {
		logic valid;   // One-cycle strobe per pixel
		rgb_t rgb;
	} cam_pixel_t;

	typedef struct packed {
		logic de;   // Data enable, active region
		logic hs;   // Active high pulse
		logic vs;   // Active high pulse
	} video_sync_t;

	typedef struct packed {
		video_sync_t sync;
		rgb_t        rgb;
	} video_out_t;

	typedef enum logic [1:0] {PAT_WAIT, PAT_RED, PAT_BLUE} pattern_state_t;
	typedef enum logic {BYTE_HIGH, BYTE_LOW} byte_phase_t;

endpackage

// ==== hdl/video_timing.sv ====
/*
 * Video timing generator
 * Horizontal and vertical counters for 640x480 at 60 Hz with
 * registered de, hs and vs decode
 */

module video_timing (
	input  logic                   clk_25_2m,
	input  logic                   reset,
	output video_pkg::video_sync_t sync
);

	video_pkg::hcount_t hcount;   // 0 is the first active pixel of a line
	video_pkg::vcount_t vcount;   // 0 is the first active line
	logic               h_end;
	logic               v_end;
	logic               h_active;
	logic               v_active;
	logic               h_pulse;
	logic               v_pulse;

	//============================================================
	// Region decode from the current counter state
	//============================================================
	always_comb begin
		h_end    = (hcount == video_pkg::hcount_t'(video_pkg::H_TOTAL - 1));
		v_end    = (vcount == video_pkg::vcount_t'(video_pkg::V_TOTAL - 1));
		h_active = (hcount < video_pkg::hcount_t'(video_pkg::H_ACTIVE));
		v_active = (vcount < video_pkg::vcount_t'(video_pkg::V_ACTIVE));

		// Sync pulse sits after the front porch
		h_pulse = (hcount >= video_pkg::hcount_t'(video_pkg::H_ACTIVE + video_pkg::H_FP)) &&
			(hcount < video_pkg::hcount_t'(video_pkg::H_ACTIVE + video_pkg::H_FP +
			video_pkg::H_SYNC));
		v_pulse = (vcount >= video_pkg::vcount_t'(video_pkg::V_ACTIVE + video_pkg::V_FP)) &&
			(vcount < video_pkg::vcount_t'(video_pkg::V_ACTIVE + video_pkg::V_FP +
			video_pkg::V_SYNC));
	end

	//============================================================
	// Counters and output registers
	//============================================================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			hcount <= '0;
			// Start on the first vertical sync line
			vcount <= video_pkg::vcount_t'(video_pkg::V_ACTIVE + video_pkg::V_FP);
			sync   <= '0;   // All syncs low in reset
		end else begin
			if (h_end) begin
				hcount <= '0;
				if (v_end)
					vcount <= '0;   // Wrap to top of frame
				else
					vcount <= vcount + 1'b1;
			end else begin
				hcount <= hcount + 1'b1;
			end

			// One cycle behind the counters
			sync.de <= h_active & v_active;
			sync.hs <= h_pulse;
			sync.vs <= v_pulse;   // Whole lines, edges at hcount 0
		end
	end

endmodule

// ==== hdl/cam_capture.sv ====
/*
 * OV7670 style camera capture
 * Brings the camera pins into the 25.2 MHz domain, pairs bytes into
 * RGB565 pixels and expands them to 24-bit RGB
 */

module cam_capture (
	input  logic                  clk_25_2m,
	input  logic                  reset,
	input  logic                  cam_pclk,
	input  logic                  cam_href,
	input  logic                  cam_vsync,
	input  video_pkg::cam_byte_t  cam_data,
	output video_pkg::cam_pixel_t cam_pix
);

	logic [2:0]            pclk_sync;   // Two sync stages plus edge stage
	logic [1:0]            href_sync;
	logic [1:0]            vsync_sync;
	video_pkg::cam_byte_t  data_s1;
	video_pkg::cam_byte_t  data_s2;     // Lines up with pclk_sync[1]
	video_pkg::cam_byte_t  high_byte;   // First byte of the pair
	video_pkg::byte_phase_t phase;
	video_pkg::rgb565_t    pix565;
	video_pkg::rgb_t       pix_rgb;
	logic                  byte_take;

	//============================================================
	// Pin synchronisers
	//============================================================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			pclk_sync  <= '0;
			href_sync  <= '0;
			vsync_sync <= '0;
		end else begin
			pclk_sync  <= {pclk_sync[1:0], cam_pclk};
			href_sync  <= {href_sync[0], cam_href};
			vsync_sync <= {vsync_sync[0], cam_vsync};
		end
		data_s1 <= cam_data;   // Data bus, same depth as pclk
		data_s2 <= data_s1;
	end

	// Rising pclk with href high carries one byte
	assign byte_take = pclk_sync[1] & ~pclk_sync[2] & href_sync[1];

	// Pair and expand, top bits copied into the low bits
	assign pix565  = {high_byte, data_s2};
	assign pix_rgb = {pix565[15:11], pix565[15:13],   // Red
		pix565[10:5], pix565[10:9],                   // Green
		pix565[4:0], pix565[4:2]};                    // Blue

	//============================================================
	// Byte phase FSM
	//============================================================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			phase         <= video_pkg::BYTE_HIGH;
			cam_pix.valid <= 1'b0;
		end else begin
			cam_pix.valid <= 1'b0;   // Strobe by default low
			if (vsync_sync[1]) begin
				phase <= video_pkg::BYTE_HIGH;   // Realign each frame
			end else if (byte_take) begin
				case (phase)
					video_pkg::BYTE_HIGH: begin
						high_byte <= data_s2;
						phase     <= video_pkg::BYTE_LOW;
					end
					video_pkg::BYTE_LOW: begin
						cam_pix.rgb   <= pix_rgb;
						cam_pix.valid <= 1'b1;
						phase         <= video_pkg::BYTE_HIGH;
					end
					default: phase <= video_pkg::BYTE_HIGH;
				endcase
			end
		end
	end

endmodule

// ==== hdl/pixel_source.sv ====
/*
 * Pixel source select
 * Feeds the pixel FIFO from the camera or from a red and blue test
 * pattern, and flags camera pixels lost to a full FIFO
 */

module pixel_source (
	input  logic                   clk_25_2m,
	input  logic                   reset,
	input  logic                   source_sel,   // 1 for test pattern
	input  video_pkg::cam_pixel_t  cam_pix,
	input  video_pkg::video_sync_t sync,
	input  logic                   full,
	output logic                   wr_req,
	output video_pkg::rgb_t        wr_data,
	output logic                   cam_overflow
);

	logic                      vs_d;
	logic                      vs_rise;    // Frame start
	video_pkg::pattern_state_t pat_state;
	video_pkg::pix_count_t     pat_count;  // Pattern pixels written
	video_pkg::rgb_t           pat_rgb;
	logic                      pat_write;
	logic                      cam_req_q;  // Camera pixel with room
	video_pkg::rgb_t           cam_data_q;

	assign vs_rise = sync.vs & ~vs_d;

	// Pattern writes straight off full, so it can run every cycle
	assign pat_write = source_sel & (pat_state != video_pkg::PAT_WAIT) & ~full;
	assign pat_rgb   = (pat_state == video_pkg::PAT_BLUE) ? video_pkg::PATTERN_BLUE :
		video_pkg::PATTERN_RED;

	assign wr_req  = pat_write | (~source_sel & cam_req_q);
	assign wr_data = source_sel ? pat_rgb : cam_data_q;

	//============================================================
	// Pattern FSM and overflow flag
	//============================================================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			vs_d         <= 1'b0;
			pat_state    <= video_pkg::PAT_WAIT;   // Idle until first vs
			pat_count    <= '0;
			cam_req_q    <= 1'b0;
			cam_overflow <= 1'b0;
		end else begin
			vs_d      <= sync.vs;
			cam_req_q <= cam_pix.valid & ~full;   // Pixels at least 4 cycles apart

			if (vs_rise) begin
				pat_state <= video_pkg::PAT_RED;   // Restart each frame
				pat_count <= '0;
			end else if (pat_write) begin
				pat_count <= pat_count + 1'b1;
				case (pat_state)
					video_pkg::PAT_RED:  pat_state <= video_pkg::PAT_BLUE;
					video_pkg::PAT_BLUE: pat_state <= video_pkg::PAT_RED;
					default:             pat_state <= video_pkg::PAT_WAIT;
				endcase
				// Last pixel of the frame
				if (pat_count == video_pkg::pix_count_t'(video_pkg::FRAME_PIXELS - 1))
					pat_state <= video_pkg::PAT_WAIT;
			end

			// Dropped camera pixel beats the frame-start clear
			if (~source_sel & cam_pix.valid & full)
				cam_overflow <= 1'b1;
			else if (vs_rise)
				cam_overflow <= 1'b0;
		end
		if (cam_pix.valid)
			cam_data_q <= cam_pix.rgb;
	end

endmodule

// ==== hdl/pixel_fifo.sv ====
/*
 * Pixel FIFO
 * Single-clock FIFO of 24-bit pixels with wrap-bit pointers and a
 * registered read port
 */

module pixel_fifo (
	input  logic            clk_25_2m,
	input  logic            reset,
	input  logic            wr_req,
	input  video_pkg::rgb_t wr_data,
	output logic            full,
	input  logic            rd_req,
	output video_pkg::rgb_t rd_data,
	output logic            empty
);

	video_pkg::rgb_t   mem [video_pkg::FIFO_DEPTH];
	video_pkg::fifo_ptr_t wr_ptr;
	video_pkg::fifo_ptr_t rd_ptr;
	logic              wr_en;
	logic              rd_en;

	//============================================================
	// Status from pointer compare
	//============================================================
	// Same address, wrap bits differ
	assign full  = (wr_ptr[video_pkg::FIFO_AW] != rd_ptr[video_pkg::FIFO_AW]) &&
		(wr_ptr[video_pkg::FIFO_AW-1:0] == rd_ptr[video_pkg::FIFO_AW-1:0]);
	assign empty = (wr_ptr == rd_ptr);

	// Guard against requests at the wrong time
	assign wr_en = wr_req & ~full;
	assign rd_en = rd_req & ~empty;

	// Pointers
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage and registered read port
	always_ff @(posedge clk_25_2m) begin
		if (wr_en)
			mem[wr_ptr[video_pkg::FIFO_AW-1:0]] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_ptr[video_pkg::FIFO_AW-1:0]];   // Valid next cycle
	end

endmodule

// ==== hdl/scan_out.sv ====
/*
 * Video scan-out
 * Pops one pixel per active cycle, lines the sync fields up with the
 * FIFO read data and flags underflow
 */

module scan_out (
	input  logic                   clk_25_2m,
	input  logic                   reset,
	input  video_pkg::video_sync_t sync,
	input  logic                   empty,
	output logic                   rd_req,
	input  video_pkg::rgb_t        rd_data,
	output video_pkg::video_out_t  video,
	output logic                   video_underflow
);

	video_pkg::video_sync_t sync_q;   // Sync delayed to match read data
	logic                   rd_valid; // A pop happened last cycle

	assign rd_req = sync.de & ~empty;

	//============================================================
	// One-cycle alignment
	//============================================================
	always_ff @(posedge clk_25_2m) begin
		if (!reset) begin
			sync_q          <= '0;
			rd_valid        <= 1'b0;
			video_underflow <= 1'b0;
		end else begin
			sync_q   <= sync;
			rd_valid <= rd_req;
			if (sync.de & empty)
				video_underflow <= 1'b1;   // Sticky until reset
		end
	end

	// Missed read and blanking both give black
	always_comb begin
		video.sync = sync_q;
		video.rgb  = rd_valid ? rd_data : video_pkg::BLACK;
	end

endmodule

// ==== hdl/video_capture_top.sv ====
/*
 * Video capture top level
 * Camera capture or test pattern into a pixel FIFO, scanned out as
 * 640x480 parallel video, all on the 25.2 MHz clock
 */

module video_capture_top (
	input  logic                  clk_25_2m,
	input  logic                  reset,         // Synchronous, active low
	input  logic                  source_sel,    // 1 for test pattern
	input  logic                  cam_pclk,
	input  logic                  cam_href,
	input  logic                  cam_vsync,
	input  video_pkg::cam_byte_t  cam_data,
	output video_pkg::video_out_t video,
	output logic                  cam_overflow,
	output logic                  video_underflow
);

	video_pkg::cam_pixel_t  cam_pix;
	video_pkg::video_sync_t sync;
	video_pkg::rgb_t        wr_data;
	video_pkg::rgb_t        rd_data;
	logic                   wr_req;
	logic                   rd_req;
	logic                   full;
	logic                   empty;

	//============================================================
	// Write side, camera or pattern into the FIFO
	//============================================================
	cam_capture u_cam_capture (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.cam_pclk  (cam_pclk),
		.cam_href  (cam_href),
		.cam_vsync (cam_vsync),
		.cam_data  (cam_data),
		.cam_pix   (cam_pix)
	);

	pixel_source u_pixel_source (
		.clk_25_2m    (clk_25_2m),
		.reset        (reset),
		.source_sel   (source_sel),
		.cam_pix      (cam_pix),
		.sync         (sync),   // vs restarts the pattern
		.full         (full),
		.wr_req       (wr_req),
		.wr_data      (wr_data),
		.cam_overflow (cam_overflow)
	);

	pixel_fifo u_pixel_fifo (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.wr_req    (wr_req),
		.wr_data   (wr_data),
		.full      (full),
		.rd_req    (rd_req),
		.rd_data   (rd_data),
		.empty     (empty)
	);

	//============================================================
	// Read side, timing and scan-out
	//============================================================
	video_timing u_video_timing (
		.clk_25_2m (clk_25_2m),
		.reset     (reset),
		.sync      (sync)
	);

	scan_out u_scan_out (
		.clk_25_2m       (clk_25_2m),
		.reset           (reset),
		.sync            (sync),
		.empty           (empty),
		.rd_req          (rd_req),
		.rd_data         (rd_data),
		.video           (video),
		.video_underflow (video_underflow)
	);

endmodule

// ==== test/tb_video_capture.sv ====
/*
 * Testbench for the video capture top level
 * Pattern mode timing and colours, then camera mode ordering,
 * overflow and underflow against a queue model
 */

module tb_video_capture;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 1700000;   // Three phases of ~420k plus margin

	logic                  clk_25_2m;
	logic                  reset;
	logic                  source_sel;
	logic                  cam_pclk;
	logic                  cam_href;
	logic                  cam_vsync;
	video_pkg::cam_byte_t  cam_data;
	video_pkg::video_out_t video;
	logic                  cam_overflow;
	logic                  video_underflow;

	int                     seed = 14665;
	int                     cycle;          // Free-running cycle count
	int                     mode;           // 0 idle, 1 pattern, 2 camera
	video_pkg::rgb_t        exp_q[$];       // Expanded pixels in send order
	bit                     used [video_pkg::rgb565_t];
	video_pkg::video_sync_t prev_sync;
	int                     last_hs;        // Cycle of the last hs rise
	int                     de_fall;        // Cycle de fell, -1 if none this line
	int                     line_de;
	int                     frame_lines;
	int                     frames_seen;
	int                     vs_cnt;
	int                     pix_idx;        // Pixel index within the frame
	bit                     overflow_seen;
	bit                     underflow_seen;

	video_capture_top u_video_capture_top (
		.clk_25_2m       (clk_25_2m),
		.reset           (reset),
		.source_sel      (source_sel),
		.cam_pclk        (cam_pclk),
		.cam_href        (cam_href),
		.cam_vsync       (cam_vsync),
		.cam_data        (cam_data),
		.video           (video),
		.cam_overflow    (cam_overflow),
		.video_underflow (video_underflow)
	);

	initial begin
		clk_25_2m = 1'b0;
		forever #2 clk_25_2m = ~clk_25_2m;   // 4 ns period
	end

	// Run limit
	always @(posedge clk_25_2m) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("TEST FAIL");
			$fatal(1, "Run timed out after %0d cycles without finishing", cycle);
		end
	end

	//============================================================
	// Error reporting
	//============================================================
	task automatic report_mismatch(input string name, input longint exp, input longint got);
		$display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
		$display("TEST FAIL");
		$fatal(1, "Value check failed");
	endtask

	task automatic report_failure(input string msg);
		$display("%0t %s", $time, msg);
		$display("TEST FAIL");
		$fatal(1, "Check failed");
	endtask

	// RGB565 to RGB888, top bits repeated into the low bits
	function automatic video_pkg::rgb_t expand565(input video_pkg::rgb565_t v);
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
		r = v[15:11];
		g = v[10:5];
		b = v[4:0];
		return {r, r[4:2], g, g[5:4], b, b[4:2]};
	endfunction

	//============================================================
	// Camera bus driver, pclk at a quarter of the clock
	//============================================================
	task automatic send_byte(input video_pkg::cam_byte_t b);
		@(posedge clk_25_2m);
		cam_pclk <= 1'b0;   // Data changes while pclk is low
		cam_data <= b;
		cam_href <= 1'b1;
		@(posedge clk_25_2m);
		@(posedge clk_25_2m);
		cam_pclk <= 1'b1;   // Byte taken on this rise
		@(posedge clk_25_2m);
	endtask

	task automatic idle_period();
		@(posedge clk_25_2m);
		cam_pclk <= 1'b0;
		cam_href <= 1'b0;
		@(posedge clk_25_2m);
		@(posedge clk_25_2m);
		cam_pclk <= 1'b1;
		@(posedge clk_25_2m);
	endtask

	// Camera frame sync, puts the byte phase back on the high byte
	task automatic pulse_vsync();
		@(posedge clk_25_2m);
		cam_href  <= 1'b0;
		cam_vsync <= 1'b1;
		repeat (6)
			@(posedge clk_25_2m);
		cam_vsync <= 1'b0;
	endtask

	// Unique non-zero value, high byte first
	task automatic send_pair();
		video_pkg::rgb565_t v;
		v = 16'($random(seed));
		while (v == 16'h0 || used.exists(v))
			v = 16'($random(seed));
		used[v] = 1'b1;
		exp_q.push_back(expand565(v));
		send_byte(v[15:8]);
		send_byte(v[7:0]);
	endtask

	//============================================================
	// Output monitor, sampled on the falling edge
	//============================================================
	task automatic check_pattern();
		video_pkg::rgb_t exp;
		assert (!video_underflow) else report_failure("video_underflow set in pattern mode");
		if (video.sync.de) begin
			line_de++;
			exp = pix_idx[0] ? video_pkg::PATTERN_BLUE : video_pkg::PATTERN_RED;
			assert (video.rgb == exp) else report_mismatch("video.rgb", exp, video.rgb);
			pix_idx++;
		end else begin
			assert (video.rgb == video_pkg::BLACK)
				else report_mismatch("video.rgb", video_pkg::BLACK, video.rgb);
		end
		if (!video.sync.de && prev_sync.de) begin   // End of an active line
			assert (line_de == 640) else report_mismatch("de cycles per line", 640, line_de);
			line_de = 0;
			frame_lines++;
			de_fall = cycle;
		end
		if (video.sync.hs && !prev_sync.hs) begin
			if (last_hs >= 0)
				assert (cycle - last_hs == 800)
					else report_mismatch("hs rise spacing", 800, cycle - last_hs);
			if (de_fall >= 0)
				assert (cycle - de_fall == 16)
					else report_mismatch("de fall to hs rise", 16, cycle - de_fall);
			de_fall = -1;
			last_hs = cycle;
		end
		if (video.sync.vs && !prev_sync.vs) begin   // Frame start
			if (frames_seen > 0)
				assert (frame_lines == 480)
					else report_mismatch("de lines per frame", 480, frame_lines);
			frames_seen++;
			frame_lines = 0;
			pix_idx = 0;
			vs_cnt = 0;
		end
		if (video.sync.vs)
			vs_cnt++;
		if (!video.sync.vs && prev_sync.vs)
			assert (vs_cnt == 1600) else report_mismatch("vs high cycles", 1600, vs_cnt);
	endtask

	task automatic check_camera();
		if (cam_overflow)
			overflow_seen = 1'b1;
		if (video_underflow)
			underflow_seen = 1'b1;
		if (!video.sync.de) begin
			assert (video.rgb == video_pkg::BLACK)
				else report_mismatch("video.rgb", video_pkg::BLACK, video.rgb);
		end else if (video.rgb != video_pkg::BLACK) begin
			// Skip pixels the FIFO dropped, order still holds
			while (exp_q.size() > 0 && exp_q[0] != video.rgb)
				void'(exp_q.pop_front());
			assert (exp_q.size() > 0) else report_failure($sformatf(
				"Output pixel %06h was never sent or came out of order", video.rgb));
			void'(exp_q.pop_front());
		end
	endtask

	always @(negedge clk_25_2m) begin
		if (reset === 1'b1 && mode == 1)
			check_pattern();
		else if (reset === 1'b1 && mode == 2)
			check_camera();
		prev_sync = video.sync;
	end

	//============================================================
	// Reset with checks, then vs must start quickly
	//============================================================
	task automatic apply_reset(input logic sel, input int next_mode);
		int n;
		mode = 0;
		@(posedge clk_25_2m);
		reset <= 1'b0;
		repeat (7) begin
			@(posedge clk_25_2m);
			source_sel <= sel;   // Only moves while reset is held
			cam_href   <= 1'b0;
			@(negedge clk_25_2m);
			assert (video.sync == '0) else report_mismatch("video.sync", 0, video.sync);
			assert (!cam_overflow) else report_mismatch("cam_overflow", 0, cam_overflow);
			assert (!video_underflow) else report_mismatch("video_underflow", 0, video_underflow);
		end
		exp_q.delete();
		prev_sync = '0;
		last_hs = -1;
		de_fall = -1;
		line_de = 0;
		frame_lines = 0;
		frames_seen = 0;
		vs_cnt = 0;
		pix_idx = 0;
		overflow_seen = 1'b0;
		underflow_seen = 1'b0;
		mode = next_mode;
		@(posedge clk_25_2m);
		reset <= 1'b1;
		n = 0;
		do begin
			@(negedge clk_25_2m);
			n++;
		end while (!video.sync.vs && n < 5);
		assert (video.sync.vs && n <= 3) else report_mismatch("cycles to first vs", 3, n);
	endtask

	initial begin
		int start;
		reset      = 1'b0;
		source_sel = 1'b1;
		cam_pclk   = 1'b0;
		cam_href   = 1'b0;
		cam_vsync  = 1'b0;
		cam_data   = '0;
		cycle      = 0;
		mode       = 0;

		// Pattern mode, two whole frames
		apply_reset(1'b1, 1);
		while (frames_seen < 3)
			@(negedge clk_25_2m);

		// Camera mode, random href bursts
		apply_reset(1'b0, 2);
		start = cycle;
		// Stray byte leaves the pairing half done until vsync realigns it
		send_byte(8'($random(seed)));
		pulse_vsync();
		while (cycle - start < 100000) begin
			repeat (1 + ($unsigned($random(seed)) % 16))
				send_pair();
			repeat (1 + ($unsigned($random(seed)) % 8))
				idle_period();
		end

		// Camera mode, steady stream through vertical blanking
		apply_reset(1'b0, 2);
		repeat (6000)
			send_pair();
		idle_period();
		assert (overflow_seen) else report_failure("cam_overflow never set by the blanking stream");
		while (video.sync.vs)
			@(negedge clk_25_2m);
		while (!video.sync.vs)
			@(negedge clk_25_2m);
		repeat (4)
			@(negedge clk_25_2m);
		assert (!cam_overflow) else report_mismatch("cam_overflow", 0, cam_overflow);
		assert (underflow_seen) else report_failure("video_underflow never set in camera mode");

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== build.f ====
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/cam_capture.sv
hdl/pixel_source.sv
hdl/pixel_fifo.sv
hdl/scan_out.sv
hdl/video_capture_top.sv
test/tb_video_capture.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_video_capture
FILELIST  := build.f
OBJ_DIR   := obj_dir

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
